// File: mips_pkg.sv
// shared types for the single-cycle MIPS subsystem
// opcode, funct and ALU operation encodings plus the control word
package mips_pkg;

  // datapath widths
  localparam int word_w     = 32;
  localparam int reg_addr_w = 5;
  localparam int reg_count  = 2 ** reg_addr_w;

  typedef logic [word_w-1:0]     word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    op_rtype = 6'h00,
    op_beq   = 6'h04,
    op_addi  = 6'h08,
    op_lw    = 6'h23,
    op_sw    = 6'h2b
  } opcode_e;

  // R-type funct, instr[5:0]
  typedef enum logic [5:0] {
    f_add = 6'h20,
    f_sub = 6'h22,
    f_and = 6'h24,
    f_or  = 6'h25,
    f_slt = 6'h2a
  } funct_e;

  // classic 3-bit ALU control encoding
  typedef enum logic [2:0] {
    alu_and = 3'b000,
    alu_or  = 3'b001,
    alu_add = 3'b010,
    alu_sub = 3'b110,
    alu_slt = 3'b111
  } alu_op_e;

  // decoded control for one instruction
  typedef struct packed {
    logic    mem_to_reg;
    logic    mem_write;
    logic    branch;
    logic    alu_src;
    logic    reg_dst;
    logic    reg_write;
    alu_op_e alu_op;
  } ctrl_t;

endpackage

// File: mips_control.sv
// main and ALU decoder for the MIPS core
// turns opcode and funct into the control word
`timescale 1ns/10ps

module mips_control import mips_pkg::*; (
  input  opcode_e opcode,
  input  funct_e  funct,
  output ctrl_t   ctrl,
  output logic    known
);

  alu_op_e rtype_op;

  // ALU decoder, only consulted for R-type
  always_comb begin
    case (funct)
      f_add:   rtype_op = alu_add;
      f_sub:   rtype_op = alu_sub;
      f_and:   rtype_op = alu_and;
      f_or:    rtype_op = alu_or;
      f_slt:   rtype_op = alu_slt;
      default: rtype_op = alu_add;
    endcase
  end

  // main decoder
  always_comb begin
    ctrl  = '0;
    known = 1'b1;
    case (opcode)
      op_rtype: begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = 1'b1;
        ctrl.alu_op    = rtype_op;
      end
      op_lw: begin
        ctrl.reg_write  = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_op     = alu_add;
      end
      op_sw: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.alu_op    = alu_add;
      end
      op_beq: begin
        // compare by subtraction, zero flag decides
        ctrl.branch = 1'b1;
        ctrl.alu_op = alu_sub;
      end
      op_addi: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = alu_add;
      end
      default: begin
        ctrl  = '0;
        known = 1'b0;
      end
    endcase
  end

endmodule

// File: mips_alu.sv
// 32-bit ALU for the MIPS core
// and, or, add, sub and signed set-less-than with a zero flag
`timescale 1ns/10ps

module mips_alu import mips_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  output word_t   y,
  output logic    zero
);

  always_comb begin
    case (op)
      alu_and: y = a & b;
      alu_or:  y = a | b;
      alu_add: y = a + b;
      alu_sub: y = a - b;
      // signed compare, result is 0 or 1
      alu_slt: y = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
      default: y = '0;
    endcase
  end

  assign zero = (y == '0);

endmodule

// File: mips_cpu.sv
// single-cycle MIPS core
// PC, decode, execute, memory access and writeback in one clock
// register file and memories sit outside on plain ports
`timescale 1ns/10ps

module mips_cpu import mips_pkg::*; #(
  parameter int imem_words = 256
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      run,
  output word_t     instr_addr,
  input  word_t     instr,
  output reg_addr_t ra1,
  output reg_addr_t ra2,
  input  word_t     rd1,
  input  word_t     rd2,
  output logic      reg_we,
  output reg_addr_t reg_wa,
  output word_t     reg_wd,
  output logic      dmem_we,
  output word_t     dmem_addr,
  output word_t     dmem_wdata,
  input  word_t     dmem_rdata,
  output word_t     pc
);

  ctrl_t ctrl;
  logic  known;
  word_t pc_plus4;
  word_t pc_branch;
  word_t pc_next;
  word_t sign_imm;
  word_t src_b;
  word_t alu_y;
  logic  alu_zero;
  logic  take_branch;

  // fetch
  assign instr_addr = pc;
  assign pc_plus4   = pc + 32'd4;

  // decode
  mips_control control_i (
    .opcode(opcode_e'(instr[31:26])),
    .funct (funct_e'(instr[5:0])),
    .ctrl  (ctrl),
    .known (known)
  );

  assign ra1      = instr[25:21];
  assign ra2      = instr[20:16];
  assign sign_imm = {{16{instr[15]}}, instr[15:0]};

  // execute
  assign src_b = ctrl.alu_src ? sign_imm : rd2;

  mips_alu alu_i (
    .a   (rd1),
    .b   (src_b),
    .op  (ctrl.alu_op),
    .y   (alu_y),
    .zero(alu_zero)
  );

  assign pc_branch   = pc_plus4 + {sign_imm[29:0], 2'b00};
  assign take_branch = ctrl.branch & alu_zero;
  assign pc_next     = take_branch ? pc_branch : pc_plus4;

  // memory
  assign dmem_we    = run & ctrl.mem_write;
  assign dmem_addr  = alu_y;
  assign dmem_wdata = rd2;

  // writeback
  assign reg_we = run & ctrl.reg_write;
  assign reg_wa = ctrl.reg_dst ? instr[15:11] : instr[20:16];
  assign reg_wd = ctrl.mem_to_reg ? dmem_rdata : alu_y;

  // pc only advances while running
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (run) begin
      pc <= pc_next;
    end
  end

  a_known_op: assert property (@(posedge clk) disable iff (!arst_n) run |-> known);

  // program must stay inside the instruction memory
  a_pc_range: assert property (@(posedge clk) disable iff (!arst_n)
    pc < word_t'(imem_words * 4));

endmodule

// File: mips_regfile.sv
// 32 x 32 register file
// two combinational read ports, one write port, r0 hardwired to zero
`timescale 1ns/10ps

module mips_regfile import mips_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  output word_t     rd1,
  output word_t     rd2,
  input  logic      we,
  input  reg_addr_t wa,
  input  word_t     wd
);

  word_t regs [reg_count];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  // r0 reads zero whatever is stored
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: mips_imem.sv
// instruction memory, word array addressed by byte address
// combinational fetch, clocked load port for the program
`timescale 1ns/10ps

module mips_imem import mips_pkg::*; #(
  parameter int imem_words = 256
) (
  input  logic  clk,
  input  word_t addr,
  output word_t rdata,
  input  logic  we,
  input  word_t waddr,
  input  word_t wdata
);

  localparam int idx_w = $clog2(imem_words);

  word_t            mem [imem_words];
  logic [idx_w-1:0] ridx;
  logic [idx_w-1:0] widx;

  // byte address to word index
  assign ridx  = addr[idx_w+1:2];
  assign widx  = waddr[idx_w+1:2];
  assign rdata = mem[ridx];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[widx] <= wdata;
    end
  end

  a_load_aligned: assert property (@(posedge clk) we |-> waddr[1:0] == 2'b00);

endmodule

// File: mips_dmem.sv
// data memory, word array addressed by byte address
// combinational read, write at the clock edge
`timescale 1ns/10ps

module mips_dmem import mips_pkg::*; #(
  parameter int dmem_words = 256
) (
  input  logic  clk,
  input  logic  we,
  input  word_t addr,
  input  word_t wdata,
  output word_t rdata
);

  localparam int idx_w = $clog2(dmem_words);

  word_t            mem [dmem_words];
  logic [idx_w-1:0] idx;

  assign idx   = addr[idx_w+1:2];
  assign rdata = mem[idx];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[idx] <= wdata;
    end
  end

  // stores come from the core ALU, catch bad base plus offset
  a_store_addr: assert property (@(posedge clk)
    we |-> (addr[1:0] == 2'b00) && (addr < word_t'(dmem_words * 4)));

endmodule

// File: mips_system.sv
// MIPS subsystem top level
// core with register file, instruction and data memory
// exposes the program load port and the write events
`timescale 1ns/10ps

module mips_system import mips_pkg::*; #(
  parameter int imem_words = 256,
  parameter int dmem_words = 256
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      run,
  input  logic      imem_we,
  input  word_t     imem_addr,
  input  word_t     imem_wdata,
  output word_t     pc,
  output logic      reg_we,
  output reg_addr_t reg_wa,
  output word_t     reg_wd,
  output logic      dmem_we,
  output word_t     dmem_addr,
  output word_t     dmem_wdata
);

  word_t     instr_addr;
  word_t     instr;
  reg_addr_t ra1;
  reg_addr_t ra2;
  word_t     rd1;
  word_t     rd2;
  word_t     dmem_rdata;

  mips_cpu #(.imem_words(imem_words)) mips_cpu_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .instr_addr(instr_addr),
    .instr     (instr),
    .ra1       (ra1),
    .ra2       (ra2),
    .rd1       (rd1),
    .rd2       (rd2),
    .reg_we    (reg_we),
    .reg_wa    (reg_wa),
    .reg_wd    (reg_wd),
    .dmem_we   (dmem_we),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_rdata(dmem_rdata),
    .pc        (pc)
  );

  // write events feed both the memories and the top-level outputs
  mips_regfile mips_regfile_i (
    .clk   (clk),
    .arst_n(arst_n),
    .ra1   (ra1),
    .ra2   (ra2),
    .rd1   (rd1),
    .rd2   (rd2),
    .we    (reg_we),
    .wa    (reg_wa),
    .wd    (reg_wd)
  );

  mips_imem #(.imem_words(imem_words)) mips_imem_i (
    .clk  (clk),
    .addr (instr_addr),
    .rdata(instr),
    .we   (imem_we),
    .waddr(imem_addr),
    .wdata(imem_wdata)
  );

  mips_dmem #(.dmem_words(dmem_words)) mips_dmem_i (
    .clk  (clk),
    .we   (dmem_we),
    .addr (dmem_addr),
    .wdata(dmem_wdata),
    .rdata(dmem_rdata)
  );

endmodule

// File: tb_mips_system.sv
// testbench for the MIPS subsystem
// loads the program from the trace, runs it and checks each write event
`timescale 1ns/10ps

module tb_mips_system import mips_pkg::*; ();

  localparam int    imem_words = 256;
  localparam int    dmem_words = 256;
  localparam string trace_path = "mips_trace.txt";

  // one trace line, key is address or register number
  typedef struct packed {
    word_t key;
    word_t value;
  } trace_entry_t;

  logic      clk;
  logic      arst_n;
  logic      run;
  logic      imem_we;
  word_t     imem_addr;
  word_t     imem_wdata;
  word_t     pc;
  logic      reg_we;
  reg_addr_t reg_wa;
  word_t     reg_wd;
  logic      dmem_we;
  word_t     dmem_addr;
  word_t     dmem_wdata;

  trace_entry_t prog_q[$];
  trace_entry_t reg_q[$];
  trace_entry_t mem_q[$];
  int           reg_idx;
  int           mem_idx;
  int           error_count;
  int           watchdog_cycles;
  logic         trace_ready;

  mips_system #(
    .imem_words(imem_words),
    .dmem_words(dmem_words)
  ) mips_system_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_wdata(imem_wdata),
    .pc        (pc),
    .reg_we    (reg_we),
    .reg_wa    (reg_wa),
    .reg_wd    (reg_wd),
    .dmem_we   (dmem_we),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic read_trace();
    int           fd;
    int           n;
    string        line;
    logic [7:0]   kind;
    word_t        a;
    word_t        b;
    trace_entry_t entry;
    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      $display("cannot open the trace file %s", trace_path);
      error_count++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        kind = 8'h00;
        a    = '0;
        b    = '0;
        n    = $sscanf(line, "%c %h %h", kind, a, b);
        // anything not starting with P, R or M is a comment or blank
        if (kind == "P" || kind == "R" || kind == "M") begin
          entry.key   = a;
          entry.value = b;
          if (n != 3) begin
            $display("malformed trace line: %s", line);
            error_count++;
          end else if (kind == "P") begin
            prog_q.push_back(entry);
          end else if (kind == "R") begin
            reg_q.push_back(entry);
          end else begin
            mem_q.push_back(entry);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic load_program();
    trace_entry_t entry;
    for (int i = 0; i < prog_q.size(); i++) begin
      entry = prog_q[i];
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= entry.key;
      imem_wdata <= entry.value;
    end
    @(posedge clk);
    imem_we <= 1'b0;
  endtask

  task automatic compare_reg_write();
    trace_entry_t exp;
    if (reg_idx >= reg_q.size()) begin
      $display("unexpected register write r%0d = %08h at %0t", reg_wa, reg_wd, $time);
      error_count++;
    end else begin
      exp = reg_q[reg_idx];
      if (reg_wa != exp.key[4:0] || reg_wd != exp.value) begin
        $display("[FAIL] %0t register write: expected r%0d = %08h, got r%0d = %08h",
                 $time, exp.key[4:0], exp.value, reg_wa, reg_wd);
        error_count++;
      end
      reg_idx++;
    end
  endtask

  task automatic compare_mem_write();
    trace_entry_t exp;
    if (mem_idx >= mem_q.size()) begin
      $display("unexpected memory write [%08h] = %08h at %0t", dmem_addr, dmem_wdata, $time);
      error_count++;
    end else begin
      exp = mem_q[mem_idx];
      if (dmem_addr != exp.key || dmem_wdata != exp.value) begin
        $display("[FAIL] %0t memory write: expected [%08h] = %08h, got [%08h] = %08h",
                 $time, exp.key, exp.value, dmem_addr, dmem_wdata);
        error_count++;
      end
      mem_idx++;
    end
  endtask

  // the program ends in a beq to itself, so the PC parks on the last word
  task automatic check_halt_pc();
    word_t halt_pc;
    if (prog_q.size() > 0) begin
      halt_pc = prog_q[prog_q.size()-1].key;
      if (pc !== halt_pc) begin
        $display("[FAIL] %0t program counter at halt: expected %08h, got %08h",
                 $time, halt_pc, pc);
        error_count++;
      end
    end
  endtask

  task automatic report_counts();
    $display("errors %0d, register events %0d of %0d, memory events %0d of %0d",
             error_count, reg_idx, reg_q.size(), mem_idx, mem_q.size());
  endtask

  // sampled mid-cycle, the event commits at the next rising edge
  always @(negedge clk) begin
    if (!run) begin
      if (reg_we || dmem_we) begin
        $display("a write event appeared while run was low at %0t", $time);
        error_count++;
      end
      // pc stays at its reset value until run rises
      if (pc !== '0) begin
        $display("[FAIL] %0t program counter while stopped: expected 00000000, got %08h",
                 $time, pc);
        error_count++;
      end
    end else begin
      if (reg_we && reg_wa != '0) begin
        compare_reg_write();
      end
      if (dmem_we) begin
        compare_mem_write();
      end
    end
  end

  initial begin
    arst_n      = 1'b0;
    run         = 1'b0;
    imem_we     = 1'b0;
    imem_addr   = '0;
    imem_wdata  = '0;
    error_count = 0;
    reg_idx     = 0;
    mem_idx     = 0;
    trace_ready = 1'b0;
    $timeformat(-9, 2, " ns", 0);
    read_trace();
    watchdog_cycles = 20 * (prog_q.size() + reg_q.size() + mem_q.size()) + 100;
    trace_ready = 1'b1;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    load_program();
    @(posedge clk);
    run <= 1'b1;
    while (reg_idx < reg_q.size() || mem_idx < mem_q.size()) begin
      @(posedge clk);
    end
    // program ends in a self loop, stray writes would show here
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_halt_pc();
    report_counts();
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    wait (trace_ready == 1'b1);
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the expected write events never came within %0d cycles",
             watchdog_cycles);
    error_count++;
    report_counts();
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: mips_trace.txt
# columns: kind (P program, R register write, M memory write), key, value; all hex
# P key is the byte address, R key the register number, M key the byte address
P 00000000 20080005  # addi r8, r0, 5
R 08 00000005
P 00000004 2009fffd  # addi r9, r0, -3
R 09 fffffffd
P 00000008 210a0037  # addi r10, r8, 0x37
R 0a 0000003c
P 0000000c 01095820  # add r11, r8, r9
R 0b 00000002
P 00000010 01096022  # sub r12, r8, r9
R 0c 00000008
P 00000014 014c6824  # and r13, r10, r12
R 0d 00000008
P 00000018 01487025  # or r14, r10, r8
R 0e 0000003d
P 0000001c 0128782a  # slt r15, r9, r8 (negative operand)
R 0f 00000001
P 00000020 0109802a  # slt r16, r8, r9
R 10 00000000
P 00000024 ad8a0004  # sw r10, 4(r12)
M 0000000c 0000003c
P 00000028 8c11000c  # lw r17, 12(r0)
R 11 0000003c
P 0000002c ad89fffc  # sw r9, -4(r12)
M 00000004 fffffffd
P 00000030 8c120004  # lw r18, 4(r0)
R 12 fffffffd
P 00000034 110d0001  # beq r8, r13, 1 (not taken)
P 00000038 20130001  # addi r19, r0, 1
R 13 00000001
P 0000003c 118d0002  # beq r12, r13, 2 (taken, to 0x48)
P 00000040 20140099  # addi r20, r0, 0x99 (skipped)
P 00000044 ac0a0000  # sw r10, 0(r0) (skipped)
P 00000048 20000007  # addi r0, r0, 7
P 0000004c 0000a820  # add r21, r0, r0
R 15 00000000
P 00000050 1000ffff  # beq r0, r0, -1 (halt loop)

// File: sim.f
mips_pkg.sv
mips_control.sv
mips_alu.sv
mips_cpu.sv
mips_regfile.sv
mips_imem.sv
mips_dmem.sv
mips_system.sv
tb_mips_system.sv

// File: Bender.yml
package:
  name: mips_system

sources:
  - mips_pkg.sv
  - mips_control.sv
  - mips_alu.sv
  - mips_cpu.sv
  - mips_regfile.sv
  - mips_imem.sv
  - mips_dmem.sv
  - mips_system.sv
  - target: simulation
    files:
      - tb_mips_system.sv
